// File: build.f
hdl/dma_pkg.sv
hdl/dma_inst_decoder.sv
hdl/dma_job_fifo.sv
hdl/dma_nd_midend.sv
hdl/dma_backend.sv
hdl/dma_ctrl.sv
testbench/tb_dma_mem.sv
testbench/tb_dma_ctrl.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module tb_dma_ctrl -o tb_dma_ctrl
	./obj_dir/tb_dma_ctrl | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_dma_ctrl.sv
// Testbench for the DMA controller with directed tests, reference copy model and timeout
module tb_dma_ctrl import dma_pkg::*; ();

  // Words moved over all tests: 1D, 2D, three queued jobs, then a full queue plus one
  localparam int TOTAL_WORDS  = 8 + 3 * 4 + 3 * 6 + (DMA_FIFO_DEPTH + 1) * 4 * 2;
  localparam int TOTAL_BURSTS = 1 + 3 + 3 + (DMA_FIFO_DEPTH + 1) * 2;
  // Two cycles per word, a few cycles of handoff per burst, and room for instructions
  localparam int CYCLE_LIMIT  = 2 * TOTAL_WORDS + 4 * TOTAL_BURSTS + 200;
  localparam int WAIT_LIMIT   = 2 * TOTAL_WORDS + 100;

  logic        clk;
  logic        arst_n;
  logic        issue_valid;
  logic [31:0] issue_instr;
  dma_data_t   issue_rs1;
  dma_data_t   issue_rs2;
  logic        l1_req;
  logic        l1_we;
  dma_addr_t   l1_addr;
  dma_data_t   l1_wdata;
  dma_data_t   l1_rdata;
  logic        l2_req;
  logic        l2_we;
  dma_addr_t   l2_addr;
  dma_data_t   l2_wdata;
  dma_data_t   l2_rdata;
  logic        start;
  logic        busy;
  logic        done;
  logic        error;
  dma_id_t     next_id;
  dma_id_t     done_id;

  int          errors;
  int          checks;
  int          cycles;
  dma_id_t     exp_next_id;
  dma_id_t     exp_done_id;
  // Configuration most recently sent to the decoder
  int          cfg_src;
  int          cfg_dst;
  int          cfg_len;
  int          cfg_reps;
  int          cfg_src_stride;
  int          cfg_dst_stride;
  // Expected contents of both memories
  dma_data_t   l1_ref [256];
  dma_data_t   l2_ref [256];

  dma_ctrl u_dut (
    .clk_i         ( clk         ),
    .arst_n_i      ( arst_n      ),
    .issue_valid_i ( issue_valid ),
    .issue_instr_i ( issue_instr ),
    .issue_rs1_i   ( issue_rs1   ),
    .issue_rs2_i   ( issue_rs2   ),
    .l1_rdata_i    ( l1_rdata    ),
    .l2_rdata_i    ( l2_rdata    ),
    .l1_req_o      ( l1_req      ),
    .l1_we_o       ( l1_we       ),
    .l1_addr_o     ( l1_addr     ),
    .l1_wdata_o    ( l1_wdata    ),
    .l2_req_o      ( l2_req      ),
    .l2_we_o       ( l2_we       ),
    .l2_addr_o     ( l2_addr     ),
    .l2_wdata_o    ( l2_wdata    ),
    .start_o       ( start       ),
    .busy_o        ( busy        ),
    .done_o        ( done        ),
    .error_o       ( error       ),
    .next_id_o     ( next_id     ),
    .done_id_o     ( done_id     )
  );

  // L2 continues the LCG stream where L1 stops
  tb_dma_mem #(.FILL_SKIP(0)) u_l1 (
    .clk_i   ( clk      ),
    .req_i   ( l1_req   ),
    .we_i    ( l1_we    ),
    .addr_i  ( l1_addr  ),
    .wdata_i ( l1_wdata ),
    .rdata_o ( l1_rdata )
  );

  tb_dma_mem #(.FILL_SKIP(256)) u_l2 (
    .clk_i   ( clk      ),
    .req_i   ( l2_req   ),
    .we_i    ( l2_we    ),
    .addr_i  ( l2_addr  ),
    .wdata_i ( l2_wdata ),
    .rdata_o ( l2_rdata )
  );

  always #10 clk = ~clk;

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("%0d checks, %0d errors", checks, errors + 1);
      $display("sim failed");
      $finish;
    end
  end

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Drives one instruction for a single cycle, returning on the next falling edge
  task automatic send_instr(input logic [2:0] funct3, input dma_data_t rs1,
                            input dma_data_t rs2);
    issue_valid = 1'b1;
    issue_instr = {17'd0, funct3, 5'd0, DMA_OPCODE};
    issue_rs1   = rs1;
    issue_rs2   = rs2;
    @(negedge clk);
    issue_valid = 1'b0;
    issue_instr = '0;
    issue_rs1   = '0;
    issue_rs2   = '0;
  endtask

  task automatic configure_job(input int src, input int dst, input int len, input int reps,
                               input int src_stride, input int dst_stride);
    cfg_src        = src;
    cfg_dst        = dst;
    cfg_len        = len;
    cfg_reps       = reps;
    cfg_src_stride = src_stride;
    cfg_dst_stride = dst_stride;
    send_instr(DMA_F3_ADDR, src, dst);
    send_instr(DMA_F3_SIZE, len, reps);
    send_instr(DMA_F3_STRIDE, src_stride, dst_stride);
  endtask

  // A start answers in the next cycle with either start_o or error_o
  task automatic start_job(input logic dir, input bit accept);
    send_instr(DMA_F3_START, {31'd0, dir}, 32'd0);
    if (accept) begin
      exp_next_id = exp_next_id + 4'd1;
    end
    expect_equal("start_o", 32'(start), accept ? 32'd1 : 32'd0);
    expect_equal("error_o", 32'(error), accept ? 32'd0 : 32'd1);
    expect_equal("next_id_o", 32'(next_id), 32'(exp_next_id));
  endtask

  // Applies the current configuration to the expected memories, row by row
  task automatic model_copy(input logic dir);
    int s;
    int d;
    for (int r = 0; r < cfg_reps; r++) begin
      for (int w = 0; w < cfg_len; w++) begin
        s = (cfg_src + r * cfg_src_stride + w) % 256;
        d = (cfg_dst + r * cfg_dst_stride + w) % 256;
        if (dir == DMA_DIR_L2_TO_L1) begin
          l1_ref[d] = l2_ref[s];
        end else begin
          l2_ref[d] = l1_ref[s];
        end
      end
    end
  endtask

  // Waits for the next done pulse and checks that IDs retire in order
  task automatic wait_done(input bit check_busy);
    int waited;
    waited = 0;
    while (!done && waited < WAIT_LIMIT) begin
      if (check_busy) begin
        expect_equal("busy_o", 32'(busy), 32'd1);
      end
      @(negedge clk);
      waited = waited + 1;
    end
    if (!done) begin
      errors = errors + 1;
      $display("No done_o pulse arrived within %0d cycles", WAIT_LIMIT);
    end else begin
      exp_done_id = exp_done_id + 4'd1;
      expect_equal("done_id_o", 32'(done_id), 32'(exp_done_id));
      @(negedge clk);
    end
  endtask

  // Every word of both memories is compared, so untouched words are covered too
  task automatic compare_memories();
    for (int i = 0; i < 256; i++) begin
      expect_equal($sformatf("u_l1.mem_q[0x%02h]", i), u_l1.mem_q[i], l1_ref[i]);
      expect_equal($sformatf("u_l2.mem_q[0x%02h]", i), u_l2.mem_q[i], l2_ref[i]);
    end
  endtask

  task automatic load_reference();
    for (int i = 0; i < 256; i++) begin
      l1_ref[i] = u_l1.mem_q[i];
      l2_ref[i] = u_l2.mem_q[i];
    end
  endtask

  task automatic test_reset_state();
    expect_equal("l1_req_o", 32'(l1_req), 32'd0);
    expect_equal("l2_req_o", 32'(l2_req), 32'd0);
    expect_equal("start_o", 32'(start), 32'd0);
    expect_equal("done_o", 32'(done), 32'd0);
    expect_equal("error_o", 32'(error), 32'd0);
    expect_equal("busy_o", 32'(busy), 32'd0);
    expect_equal("next_id_o", 32'(next_id), 32'd0);
    // The last completed ID starts one below the first one handed out
    expect_equal("done_id_o", 32'(done_id), 32'd15);
  endtask

  task automatic test_copy_1d();
    configure_job(32'h10, 32'h20, 8, 1, 0, 0);
    start_job(DMA_DIR_L2_TO_L1, 1'b1);
    model_copy(DMA_DIR_L2_TO_L1);
    wait_done(1'b0);
    compare_memories();
  endtask

  task automatic test_copy_2d();
    // Strides larger than the row length leave gaps that must stay untouched
    configure_job(32'h40, 32'h80, 4, 3, 8, 12);
    start_job(DMA_DIR_L1_TO_L2, 1'b1);
    model_copy(DMA_DIR_L1_TO_L2);
    wait_done(1'b0);
    compare_memories();
  endtask

  task automatic test_queued_jobs();
    for (int j = 0; j < 3; j++) begin
      configure_job(32'h30 + 8 * j, 32'h60 + 16 * j, 6, 1, 0, 0);
      start_job(DMA_DIR_L2_TO_L1, 1'b1);
      model_copy(DMA_DIR_L2_TO_L1);
    end
    for (int j = 0; j < 3; j++) begin
      wait_done(1'b1);
    end
    expect_equal("busy_o", 32'(busy), 32'd0);
    compare_memories();
  endtask

  task automatic test_rejected_starts();
    // An empty row is rejected and takes no ID
    configure_job(32'hC0, 32'hD0, 0, 2, 5, 6);
    start_job(DMA_DIR_L1_TO_L2, 1'b0);
    configure_job(32'hC0, 32'hD0, 4, 2, 5, 6);
    // One job goes straight to the mid-end, the rest fill the FIFO
    for (int k = 0; k < DMA_FIFO_DEPTH + 1; k++) begin
      start_job(DMA_DIR_L1_TO_L2, 1'b1);
      model_copy(DMA_DIR_L1_TO_L2);
    end
    start_job(DMA_DIR_L1_TO_L2, 1'b0);
    for (int k = 0; k < DMA_FIFO_DEPTH + 1; k++) begin
      wait_done(1'b1);
    end
    expect_equal("busy_o", 32'(busy), 32'd0);
    compare_memories();
  endtask

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    issue_valid = 1'b0;
    issue_instr = '0;
    issue_rs1   = '0;
    issue_rs2   = '0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    exp_next_id = '0;
    exp_done_id = '1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    load_reference();
    test_reset_state();
    test_copy_1d();
    test_copy_2d();
    test_queued_jobs();
    test_rejected_starts();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: testbench/tb_dma_mem.sv
// Behavioral 256-word memory model with one-cycle read latency and an LCG fill pattern
module tb_dma_mem import dma_pkg::*; #(
  // Number of LCG steps skipped before the fill, so each instance gets its own stretch
  parameter int FILL_SKIP = 0
) (
  input  logic      clk_i,
  input  logic      req_i,
  input  logic      we_i,
  input  dma_addr_t addr_i,
  input  dma_data_t wdata_i,
  output dma_data_t rdata_o
);

  localparam logic [31:0] LCG_SEED = 32'd45914;

  dma_data_t mem_q [256];

  // Numerical Recipes constants, full 32-bit period
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word i holds LCG step FILL_SKIP + i + 1, so every address gets its own value
  initial begin
    logic [31:0] state;
    // Read data is defined before the first request arrives
    rdata_o <= '0;
    state = LCG_SEED;
    for (int i = 0; i < FILL_SKIP; i++) begin
      state = lcg_next(state);
    end
    for (int i = 0; i < 256; i++) begin
      state = lcg_next(state);
      mem_q[i] <= state;
    end
  end

  // Only the low eight address bits select a word
  always @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i[7:0]] <= wdata_i;
    end else if (req_i) begin
      // Read data shows up in the cycle after the request
      rdata_o <= mem_q[addr_i[7:0]];
    end
  end

endmodule

// File: hdl/dma_ctrl.sv
// DMA controller top level joining decoder, job FIFO, mid-end, back-end and the L1/L2 port steering
module dma_ctrl import dma_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        issue_valid_i,
  input  logic [31:0] issue_instr_i,
  input  dma_data_t   issue_rs1_i,
  input  dma_data_t   issue_rs2_i,
  input  dma_data_t   l1_rdata_i,
  input  dma_data_t   l2_rdata_i,
  output logic        l1_req_o,
  output logic        l1_we_o,
  output dma_addr_t   l1_addr_o,
  output dma_data_t   l1_wdata_o,
  output logic        l2_req_o,
  output logic        l2_we_o,
  output dma_addr_t   l2_addr_o,
  output dma_data_t   l2_wdata_o,
  output logic        start_o,
  output logic        busy_o,
  output logic        done_o,
  output logic        error_o,
  output dma_id_t     next_id_o,
  output dma_id_t     done_id_o
);

  // Decoder to FIFO job word
  logic      dec_push;
  dma_addr_t dec_src;
  dma_addr_t dec_dst;
  dma_len_t  dec_len;
  dma_reps_t dec_reps;
  dma_addr_t dec_src_stride;
  dma_addr_t dec_dst_stride;
  logic      dec_dir;
  logic      fifo_full;
  logic      fifo_empty;

  // FIFO to mid-end job word
  logic      job_valid;
  logic      job_ready;
  dma_addr_t job_src;
  dma_addr_t job_dst;
  dma_len_t  job_len;
  dma_reps_t job_reps;
  dma_addr_t job_src_stride;
  dma_addr_t job_dst_stride;
  logic      job_dir;

  // Mid-end to back-end burst and status
  logic      burst_valid;
  logic      burst_ready;
  dma_addr_t burst_src;
  dma_addr_t burst_dst;
  dma_len_t  burst_len;
  logic      burst_dir;
  logic      burst_done;
  logic      retire;
  logic      me_busy;

  // Back-end memory side before steering
  logic      be_rd_req;
  dma_addr_t be_rd_addr;
  dma_data_t be_rd_data;
  logic      be_wr_req;
  dma_addr_t be_wr_addr;
  dma_data_t be_wr_data;
  logic      be_dir;
  logic      be_busy;
  logic      to_l1;
  logic      to_l2;

  dma_inst_decoder u_decoder (
    .clk_i            ( clk_i          ),
    .arst_n_i         ( arst_n_i       ),
    .issue_valid_i    ( issue_valid_i  ),
    .issue_instr_i    ( issue_instr_i  ),
    .issue_rs1_i      ( issue_rs1_i    ),
    .issue_rs2_i      ( issue_rs2_i    ),
    .fifo_full_i      ( fifo_full      ),
    .retire_i         ( retire         ),
    .job_push_o       ( dec_push       ),
    .job_src_o        ( dec_src        ),
    .job_dst_o        ( dec_dst        ),
    .job_len_o        ( dec_len        ),
    .job_reps_o       ( dec_reps       ),
    .job_src_stride_o ( dec_src_stride ),
    .job_dst_stride_o ( dec_dst_stride ),
    .job_dir_o        ( dec_dir        ),
    .start_o          ( start_o        ),
    .error_o          ( error_o        ),
    .done_o           ( done_o         ),
    .next_id_o        ( next_id_o      ),
    .done_id_o        ( done_id_o      )
  );

  dma_job_fifo u_job_fifo (
    .clk_i            ( clk_i          ),
    .arst_n_i         ( arst_n_i       ),
    .push_i           ( dec_push       ),
    .job_src_i        ( dec_src        ),
    .job_dst_i        ( dec_dst        ),
    .job_len_i        ( dec_len        ),
    .job_reps_i       ( dec_reps       ),
    .job_src_stride_i ( dec_src_stride ),
    .job_dst_stride_i ( dec_dst_stride ),
    .job_dir_i        ( dec_dir        ),
    .ready_i          ( job_ready      ),
    .full_o           ( fifo_full      ),
    .valid_o          ( job_valid      ),
    .job_src_o        ( job_src        ),
    .job_dst_o        ( job_dst        ),
    .job_len_o        ( job_len        ),
    .job_reps_o       ( job_reps       ),
    .job_src_stride_o ( job_src_stride ),
    .job_dst_stride_o ( job_dst_stride ),
    .job_dir_o        ( job_dir        ),
    .empty_o          ( fifo_empty     )
  );

  dma_nd_midend u_midend (
    .clk_i            ( clk_i          ),
    .arst_n_i         ( arst_n_i       ),
    .job_valid_i      ( job_valid      ),
    .job_src_i        ( job_src        ),
    .job_dst_i        ( job_dst        ),
    .job_len_i        ( job_len        ),
    .job_reps_i       ( job_reps       ),
    .job_src_stride_i ( job_src_stride ),
    .job_dst_stride_i ( job_dst_stride ),
    .job_dir_i        ( job_dir        ),
    .burst_ready_i    ( burst_ready    ),
    .burst_done_i     ( burst_done     ),
    .job_ready_o      ( job_ready      ),
    .burst_valid_o    ( burst_valid    ),
    .burst_src_o      ( burst_src      ),
    .burst_dst_o      ( burst_dst      ),
    .burst_len_o      ( burst_len      ),
    .burst_dir_o      ( burst_dir      ),
    .retire_o         ( retire         ),
    .busy_o           ( me_busy        )
  );

  dma_backend u_backend (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .burst_valid_i ( burst_valid ),
    .burst_src_i   ( burst_src   ),
    .burst_dst_i   ( burst_dst   ),
    .burst_len_i   ( burst_len   ),
    .burst_dir_i   ( burst_dir   ),
    .rd_data_i     ( be_rd_data  ),
    .burst_ready_o ( burst_ready ),
    .burst_done_o  ( burst_done  ),
    .rd_req_o      ( be_rd_req   ),
    .rd_addr_o     ( be_rd_addr  ),
    .wr_req_o      ( be_wr_req   ),
    .wr_addr_o     ( be_wr_addr  ),
    .wr_data_o     ( be_wr_data  ),
    .dir_o         ( be_dir      ),
    .busy_o        ( be_busy     )
  );

  // Only one direction runs at a time, so each port sees either the read or the write side
  assign to_l1 = (be_dir == DMA_DIR_L2_TO_L1);
  assign to_l2 = (be_dir == DMA_DIR_L1_TO_L2);

  assign l1_req_o   = to_l1 ? be_wr_req : be_rd_req;
  assign l1_we_o    = to_l1 && be_wr_req;
  assign l1_addr_o  = to_l1 ? be_wr_addr : be_rd_addr;
  assign l1_wdata_o = be_wr_data;

  assign l2_req_o   = to_l2 ? be_wr_req : be_rd_req;
  assign l2_we_o    = to_l2 && be_wr_req;
  assign l2_addr_o  = to_l2 ? be_wr_addr : be_rd_addr;
  assign l2_wdata_o = be_wr_data;

  // Read data comes back from whichever port is the source
  assign be_rd_data = to_l1 ? l2_rdata_i : l1_rdata_i;

  // Queued jobs count as busy even before the mid-end picks them up
  assign busy_o = !fifo_empty || me_busy || be_busy;

endmodule

// File: hdl/dma_backend.sv
// Back-end copy engine that moves one burst word by word from source to destination
module dma_backend import dma_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      burst_valid_i,
  input  dma_addr_t burst_src_i,
  input  dma_addr_t burst_dst_i,
  input  dma_len_t  burst_len_i,
  input  logic      burst_dir_i,
  input  dma_data_t rd_data_i,
  output logic      burst_ready_o,
  output logic      burst_done_o,
  output logic      rd_req_o,
  output dma_addr_t rd_addr_o,
  output logic      wr_req_o,
  output dma_addr_t wr_addr_o,
  output dma_data_t wr_data_o,
  output logic      dir_o,
  output logic      busy_o
);

  backend_state_e state_q;
  dma_len_t       words_left_q;
  logic           done_q;
  logic           dir_q;
  logic           last_word;
  dma_addr_t      src_q;
  dma_addr_t      dst_q;

  assign burst_ready_o = (state_q == BE_IDLE);
  assign last_word     = (words_left_q == dma_len_t'(1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= BE_IDLE;
      words_left_q <= '0;
      done_q       <= 1'b0;
      dir_q        <= DMA_DIR_L2_TO_L1;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        BE_IDLE: begin
          if (burst_valid_i) begin
            words_left_q <= burst_len_i;
            dir_q        <= burst_dir_i;
            state_q      <= BE_READ;
          end
        end
        BE_READ: begin
          state_q <= BE_WRITE;
        end
        BE_WRITE: begin
          words_left_q <= words_left_q - 1'b1;
          if (last_word) begin
            done_q  <= 1'b1;
            state_q <= BE_IDLE;
          end else begin
            state_q <= BE_READ;
          end
        end
        default: state_q <= BE_IDLE;
      endcase
    end
  end

  // Both addresses step by one word after each write
  always_ff @(posedge clk_i) begin
    if (burst_valid_i && burst_ready_o) begin
      src_q <= burst_src_i;
      dst_q <= burst_dst_i;
    end else if (state_q == BE_WRITE) begin
      src_q <= src_q + 1'b1;
      dst_q <= dst_q + 1'b1;
    end
  end

  // Read data arrives one cycle after the request, which is the write cycle
  assign rd_req_o  = (state_q == BE_READ);
  assign rd_addr_o = src_q;
  assign wr_req_o  = (state_q == BE_WRITE);
  assign wr_addr_o = dst_q;
  assign wr_data_o = rd_data_i;

  // Direction is held for the whole burst so the port steering stays put
  assign dir_o        = dir_q;
  assign burst_done_o = done_q;
  assign busy_o       = (state_q != BE_IDLE);

endmodule

// File: hdl/dma_nd_midend.sv
// Mid-end that splits a two-dimensional job into one burst per row and reports retirement
module dma_nd_midend import dma_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      job_valid_i,
  input  dma_addr_t job_src_i,
  input  dma_addr_t job_dst_i,
  input  dma_len_t  job_len_i,
  input  dma_reps_t job_reps_i,
  input  dma_addr_t job_src_stride_i,
  input  dma_addr_t job_dst_stride_i,
  input  logic      job_dir_i,
  input  logic      burst_ready_i,
  input  logic      burst_done_i,
  output logic      job_ready_o,
  output logic      burst_valid_o,
  output dma_addr_t burst_src_o,
  output dma_addr_t burst_dst_o,
  output dma_len_t  burst_len_o,
  output logic      burst_dir_o,
  output logic      retire_o,
  output logic      busy_o
);

  midend_state_e state_q;
  dma_reps_t     rows_left_q;
  logic          retire_q;
  logic          last_row;
  logic          row_done;
  dma_addr_t     src_q;
  dma_addr_t     dst_q;
  dma_addr_t     src_stride_q;
  dma_addr_t     dst_stride_q;
  dma_len_t      len_q;
  logic          dir_q;

  assign job_ready_o   = (state_q == MID_IDLE);
  assign burst_valid_o = (state_q == MID_ISSUE);
  assign row_done      = (state_q == MID_WAIT) && burst_done_i;
  assign last_row      = (rows_left_q == dma_reps_t'(1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= MID_IDLE;
      rows_left_q <= '0;
      retire_q    <= 1'b0;
    end else begin
      retire_q <= 1'b0;
      case (state_q)
        MID_IDLE: begin
          if (job_valid_i) begin
            rows_left_q <= job_reps_i;
            state_q     <= MID_ISSUE;
          end
        end
        MID_ISSUE: begin
          // The back-end drops ready while busy, so the burst stays on offer
          if (burst_ready_i) begin
            state_q <= MID_WAIT;
          end
        end
        MID_WAIT: begin
          if (burst_done_i) begin
            rows_left_q <= rows_left_q - 1'b1;
            if (last_row) begin
              retire_q <= 1'b1;
              state_q  <= MID_IDLE;
            end else begin
              state_q <= MID_ISSUE;
            end
          end
        end
        default: state_q <= MID_IDLE;
      endcase
    end
  end

  // Row addresses start at the job base and step by the strides after each row
  always_ff @(posedge clk_i) begin
    if (job_valid_i && job_ready_o) begin
      src_q        <= job_src_i;
      dst_q        <= job_dst_i;
      src_stride_q <= job_src_stride_i;
      dst_stride_q <= job_dst_stride_i;
      len_q        <= job_len_i;
      dir_q        <= job_dir_i;
    end else if (row_done) begin
      src_q <= src_q + src_stride_q;
      dst_q <= dst_q + dst_stride_q;
    end
  end

  assign burst_src_o = src_q;
  assign burst_dst_o = dst_q;
  assign burst_len_o = len_q;
  assign burst_dir_o = dir_q;
  assign retire_o    = retire_q;

  // Busy runs from job accept up to and including the retire strobe
  assign busy_o = (state_q != MID_IDLE) || retire_q;

endmodule

// File: hdl/dma_job_fifo.sv
// Job FIFO holding complete descriptors between the decoder and the mid-end
module dma_job_fifo import dma_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      push_i,
  input  dma_addr_t job_src_i,
  input  dma_addr_t job_dst_i,
  input  dma_len_t  job_len_i,
  input  dma_reps_t job_reps_i,
  input  dma_addr_t job_src_stride_i,
  input  dma_addr_t job_dst_stride_i,
  input  logic      job_dir_i,
  input  logic      ready_i,
  output logic      full_o,
  output logic      valid_o,
  output dma_addr_t job_src_o,
  output dma_addr_t job_dst_o,
  output dma_len_t  job_len_o,
  output dma_reps_t job_reps_o,
  output dma_addr_t job_src_stride_o,
  output dma_addr_t job_dst_stride_o,
  output logic      job_dir_o,
  output logic      empty_o
);

  logic [DMA_JOB_W-1:0]      mem_q [DMA_FIFO_DEPTH];
  logic [DMA_JOB_W-1:0]      wr_job;
  logic [DMA_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [DMA_FIFO_PTR_W-1:0] rd_ptr_q;
  dma_fifo_cnt_t             count_q;
  dma_fifo_cnt_t             count_d;
  logic                      push;
  logic                      pop;

  assign wr_job = {job_src_i, job_dst_i, job_len_i, job_reps_i,
                   job_src_stride_i, job_dst_stride_i, job_dir_i};

  // A push into a full queue is dropped, the decoder never issues one
  assign push = push_i && (count_q != DMA_FIFO_CNT_MAX);
  assign pop  = valid_o && ready_i;

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  // Full reports the occupancy after this edge, since the decoder checks it one
  // cycle before its own push lands
  assign full_o  = (count_d == DMA_FIFO_CNT_MAX);
  assign valid_o = (count_q != '0);
  assign empty_o = (count_q == '0);

  // Pointers wrap on their own because the depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      count_q <= count_d;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_job;
    end
  end

  assign {job_src_o, job_dst_o, job_len_o, job_reps_o,
          job_src_stride_o, job_dst_stride_o, job_dir_o} = mem_q[rd_ptr_q];

endmodule

// File: hdl/dma_inst_decoder.sv
// Instruction decoder with configuration registers, job launch, transfer IDs and status strobes
module dma_inst_decoder import dma_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        issue_valid_i,
  input  logic [31:0] issue_instr_i,
  input  dma_data_t   issue_rs1_i,
  input  dma_data_t   issue_rs2_i,
  input  logic        fifo_full_i,
  input  logic        retire_i,
  output logic        job_push_o,
  output dma_addr_t   job_src_o,
  output dma_addr_t   job_dst_o,
  output dma_len_t    job_len_o,
  output dma_reps_t   job_reps_o,
  output dma_addr_t   job_src_stride_o,
  output dma_addr_t   job_dst_stride_o,
  output logic        job_dir_o,
  output logic        start_o,
  output logic        error_o,
  output logic        done_o,
  output dma_id_t     next_id_o,
  output dma_id_t     done_id_o
);

  logic       dma_instr;
  logic [2:0] funct3;
  logic       start_req;
  logic       start_ok;
  dma_addr_t  src_q;
  dma_addr_t  dst_q;
  dma_len_t   len_q;
  dma_reps_t  reps_q;
  dma_addr_t  src_stride_q;
  dma_addr_t  dst_stride_q;
  logic       dir_q;
  logic       push_q;
  logic       error_q;
  logic       done_q;
  dma_id_t    next_id_q;
  dma_id_t    done_id_q;

  // Every strobed instruction is consumed, only custom-0 ones are acted on
  assign funct3    = issue_instr_i[14:12];
  assign dma_instr = issue_valid_i && (issue_instr_i[6:0] == DMA_OPCODE);
  assign start_req = dma_instr && (funct3 == DMA_F3_START);

  // An empty job or a FIFO without room turns the start into an error
  // The FIFO full flag already looks one cycle ahead to cover the push delay
  assign start_ok = (len_q != '0) && (reps_q != '0) && !fifo_full_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      reps_q       <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      dir_q        <= DMA_DIR_L2_TO_L1;
      push_q       <= 1'b0;
      error_q      <= 1'b0;
      done_q       <= 1'b0;
      next_id_q    <= '0;
      // Nothing has retired yet, so the last completed ID sits one below the first
      done_id_q    <= '1;
    end else begin
      push_q  <= start_req && start_ok;
      error_q <= start_req && !start_ok;
      done_q  <= retire_i;
      if (dma_instr) begin
        case (funct3)
          DMA_F3_ADDR: begin
            src_q <= issue_rs1_i[DMA_ADDR_W-1:0];
            dst_q <= issue_rs2_i[DMA_ADDR_W-1:0];
          end
          DMA_F3_SIZE: begin
            len_q  <= issue_rs1_i[DMA_LEN_W-1:0];
            reps_q <= issue_rs2_i[DMA_REPS_W-1:0];
          end
          DMA_F3_STRIDE: begin
            src_stride_q <= issue_rs1_i[DMA_ADDR_W-1:0];
            dst_stride_q <= issue_rs2_i[DMA_ADDR_W-1:0];
          end
          default: begin
            // A start leaves the configuration intact for the next job
            if (start_req && start_ok) begin
              dir_q <= issue_rs1_i[0];
            end
          end
        endcase
      end
      // IDs are handed out in order and retire in the same order
      if (start_req && start_ok) begin
        next_id_q <= next_id_q + 1'b1;
      end
      if (retire_i) begin
        done_id_q <= done_id_q + 1'b1;
      end
    end
  end

  // The job word is the live configuration, sampled by the FIFO on the push cycle
  assign job_push_o       = push_q;
  assign job_src_o        = src_q;
  assign job_dst_o        = dst_q;
  assign job_len_o        = len_q;
  assign job_reps_o       = reps_q;
  assign job_src_stride_o = src_stride_q;
  assign job_dst_stride_o = dst_stride_q;
  assign job_dir_o        = dir_q;

  // The start pulse coincides with the push
  assign start_o   = push_q;
  assign error_o   = error_q;
  assign done_o    = done_q;
  assign next_id_o = next_id_q;
  assign done_id_o = done_id_q;

endmodule

// File: hdl/dma_pkg.sv
// DMA package with widths, opcodes, FIFO depth, vector typedefs and FSM state enums
package dma_pkg;

  // Field widths shared by the decoder, FIFO, mid-end and back-end
  localparam int DMA_ADDR_W = 16;
  localparam int DMA_DATA_W = 32;
  localparam int DMA_LEN_W  = 16;
  localparam int DMA_REPS_W = 8;
  localparam int DMA_ID_W   = 4;

  // Job queue depth, pointer width and width of one packed descriptor
  localparam int DMA_FIFO_DEPTH = 4;
  localparam int DMA_FIFO_PTR_W = $clog2(DMA_FIFO_DEPTH);
  // Source, destination and both strides, then length, repetitions and direction
  localparam int DMA_JOB_W = 4 * DMA_ADDR_W + DMA_LEN_W + DMA_REPS_W + 1;

  // Custom-0 major opcode, matched against instruction bits 6:0
  localparam logic [6:0] DMA_OPCODE = 7'b0001011;

  // Function codes carried in funct3
  // ADDR loads rs1 as source and rs2 as destination
  localparam logic [2:0] DMA_F3_ADDR   = 3'd0;
  // SIZE loads rs1 as words per row and rs2 as number of rows
  localparam logic [2:0] DMA_F3_SIZE   = 3'd1;
  // STRIDE loads rs1 as source stride and rs2 as destination stride
  localparam logic [2:0] DMA_F3_STRIDE = 3'd2;
  // START launches a job, with the direction in bit 0 of rs1
  localparam logic [2:0] DMA_F3_START  = 3'd3;

  // Copy direction encodings
  localparam logic DMA_DIR_L2_TO_L1 = 1'b0;
  localparam logic DMA_DIR_L1_TO_L2 = 1'b1;

  // Vector types for quantities with a meaning of their own
  typedef logic [DMA_ADDR_W-1:0]     dma_addr_t;
  typedef logic [DMA_DATA_W-1:0]     dma_data_t;
  typedef logic [DMA_LEN_W-1:0]      dma_len_t;
  typedef logic [DMA_REPS_W-1:0]     dma_reps_t;
  typedef logic [DMA_ID_W-1:0]       dma_id_t;
  typedef logic [DMA_FIFO_PTR_W:0]   dma_fifo_cnt_t;

  // Occupancy at which the job FIFO holds no more descriptors
  localparam dma_fifo_cnt_t DMA_FIFO_CNT_MAX = dma_fifo_cnt_t'(DMA_FIFO_DEPTH);

  // Mid-end FSM: wait for a job, offer a row burst, wait for that burst to finish
  typedef enum logic [1:0] {
    MID_IDLE,
    MID_ISSUE,
    MID_WAIT
  } midend_state_e;

  // Back-end FSM: each word is a read cycle followed by a write cycle
  typedef enum logic [1:0] {
    BE_IDLE,
    BE_READ,
    BE_WRITE
  } backend_state_e;

endpackage
